/* Makefile */
VERILATOR  ?= verilator
TOP        := core_bus_tb
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
src/core_bus_pkg.sv
src/read_arbiter.sv
src/read_router.sv
src/clint_timer.sv
src/core_bus_top.sv
verification/ext_mem_model.sv
verification/core_bus_tb.sv

/* src/clint_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_timer (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  core_bus_pkg::ar_req_t ar,
  output logic                  r_valid,
  input  logic                  r_ready,
  output core_bus_pkg::r_beat_t r
);

  logic [63:0] mtime;
  logic hi_sel;
  logic [core_bus_pkg::data_w-1:0] rd_word;
  logic ar_fire;

  // free-running machine timer, keeps counting under back-pressure
  always_ff @(posedge clock) begin
    if (rst) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  assign ar_ready = !r_valid;  // one read at a time
  assign ar_fire  = ar_valid && ar_ready;

  // bit 2 picks the word
  assign hi_sel  = ar.addr[2] == core_bus_pkg::mtime_hi_offset[2];
  assign rd_word = hi_sel ? mtime[63:32] : mtime[31:0];

  always_ff @(posedge clock) begin
    if (rst) begin
      r_valid <= 1'b0;
    end else if (ar_fire) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // single beat, id echoed from the request
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      r.data <= rd_word;   // value at the ar edge
      r.resp <= core_bus_pkg::resp_okay;
      r.last <= 1'b1;
      r.id   <= ar.id;
    end
  end

  // the router sends nothing new until the beat is taken
  a_one_outstanding: assert property (
    @(posedge clock) disable iff (rst) r_valid |-> !ar_valid
  ) else $error("clint_timer: new request while a response is pending");

endmodule

`default_nettype wire

/* src/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int id_w   = 4;

  // core-local timer window
  localparam logic [addr_w-1:0] clint_base_default = 32'ha000_0000;
  localparam logic [addr_w-1:0] clint_size_default = 32'h0001_0000;  // 64 KiB

  // word offsets of mtime inside the window
  localparam logic [addr_w-1:0] mtime_lo_offset = 32'h0000_0000;
  localparam logic [addr_w-1:0] mtime_hi_offset = 32'h0000_0004;

  localparam logic [1:0] resp_okay = 2'b00;

  // read address channel, 49 bits
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [id_w-1:0]   id;
    logic [7:0]        len;    // beats minus one
    logic [2:0]        size;   // log2 bytes per beat
    logic [1:0]        burst;
  } ar_req_t;

  // read data channel, 39 bits
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [1:0]        resp;
    logic              last;
    logic [id_w-1:0]   id;
  } r_beat_t;

  // write address channel, same layout as ar
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [id_w-1:0]   id;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } aw_req_t;

  // write data channel, 37 bits
  typedef struct packed {
    logic [data_w-1:0]   data;
    logic [data_w/8-1:0] strb;
    logic                last;
  } w_beat_t;

  // write response, 6 bits
  typedef struct packed {
    logic [1:0]      resp;
    logic [id_w-1:0] id;
  } b_resp_t;

endpackage

`default_nettype wire

/* src/core_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_bus_top #(
  parameter logic [core_bus_pkg::addr_w-1:0] clint_base = core_bus_pkg::clint_base_default,
  parameter logic [core_bus_pkg::addr_w-1:0] clint_size = core_bus_pkg::clint_size_default
) (
  input  logic                  clock,
  input  logic                  rst,

  // fetch port
  input  logic                  fetch_arvalid,
  output logic                  fetch_arready,
  input  core_bus_pkg::ar_req_t fetch_ar,
  output logic                  fetch_rvalid,
  input  logic                  fetch_rready,
  output core_bus_pkg::r_beat_t fetch_r,

  // load/store port
  input  logic                  ls_arvalid,
  output logic                  ls_arready,
  input  core_bus_pkg::ar_req_t ls_ar,
  output logic                  ls_rvalid,
  input  logic                  ls_rready,
  output core_bus_pkg::r_beat_t ls_r,
  input  logic                  ls_awvalid,
  output logic                  ls_awready,
  input  core_bus_pkg::aw_req_t ls_aw,
  input  logic                  ls_wvalid,
  output logic                  ls_wready,
  input  core_bus_pkg::w_beat_t ls_w,
  output logic                  ls_bvalid,
  input  logic                  ls_bready,
  output core_bus_pkg::b_resp_t ls_b,

  // external master port
  output logic                  ext_arvalid,
  input  logic                  ext_arready,
  output core_bus_pkg::ar_req_t ext_ar,
  input  logic                  ext_rvalid,
  output logic                  ext_rready,
  input  core_bus_pkg::r_beat_t ext_r,
  output logic                  ext_awvalid,
  input  logic                  ext_awready,
  output core_bus_pkg::aw_req_t ext_aw,
  output logic                  ext_wvalid,
  input  logic                  ext_wready,
  output core_bus_pkg::w_beat_t ext_w,
  input  logic                  ext_bvalid,
  output logic                  ext_bready,
  input  core_bus_pkg::b_resp_t ext_b
);

  logic                  bus_arvalid;
  logic                  bus_arready;
  core_bus_pkg::ar_req_t bus_ar;
  logic                  bus_rvalid;
  logic                  bus_rready;
  core_bus_pkg::r_beat_t bus_r;

  logic                  clint_arvalid;
  logic                  clint_arready;
  core_bus_pkg::ar_req_t clint_ar;
  logic                  clint_rvalid;
  logic                  clint_rready;
  core_bus_pkg::r_beat_t clint_r;

  read_arbiter u_arbiter (
    .clock         (clock),
    .rst           (rst),
    .fetch_arvalid (fetch_arvalid),
    .fetch_arready (fetch_arready),
    .fetch_ar      (fetch_ar),
    .fetch_rvalid  (fetch_rvalid),
    .fetch_rready  (fetch_rready),
    .fetch_r       (fetch_r),
    .ls_arvalid    (ls_arvalid),
    .ls_arready    (ls_arready),
    .ls_ar         (ls_ar),
    .ls_rvalid     (ls_rvalid),
    .ls_rready     (ls_rready),
    .ls_r          (ls_r),
    .bus_arvalid   (bus_arvalid),
    .bus_arready   (bus_arready),
    .bus_ar        (bus_ar),
    .bus_rvalid    (bus_rvalid),
    .bus_rready    (bus_rready),
    .bus_r         (bus_r)
  );

  read_router #(
    .clint_base (clint_base),
    .clint_size (clint_size)
  ) u_router (
    .clock         (clock),
    .rst           (rst),
    .bus_arvalid   (bus_arvalid),
    .bus_arready   (bus_arready),
    .bus_ar        (bus_ar),
    .bus_rvalid    (bus_rvalid),
    .bus_rready    (bus_rready),
    .bus_r         (bus_r),
    .ext_arvalid   (ext_arvalid),
    .ext_arready   (ext_arready),
    .ext_ar        (ext_ar),
    .ext_rvalid    (ext_rvalid),
    .ext_rready    (ext_rready),
    .ext_r         (ext_r),
    .clint_arvalid (clint_arvalid),
    .clint_arready (clint_arready),
    .clint_ar      (clint_ar),
    .clint_rvalid  (clint_rvalid),
    .clint_rready  (clint_rready),
    .clint_r       (clint_r)
  );

  clint_timer u_clint (
    .clock    (clock),
    .rst      (rst),
    .ar_valid (clint_arvalid),
    .ar_ready (clint_arready),
    .ar       (clint_ar),
    .r_valid  (clint_rvalid),
    .r_ready  (clint_rready),
    .r        (clint_r)
  );

  // load/store is the only writer, so writes go straight out
  assign ext_awvalid = ls_awvalid;
  assign ls_awready  = ext_awready;
  assign ext_aw      = ls_aw;
  assign ext_wvalid  = ls_wvalid;
  assign ls_wready   = ext_wready;
  assign ext_w       = ls_w;
  assign ls_bvalid   = ext_bvalid;
  assign ext_bready  = ls_bready;
  assign ls_b        = ext_b;

endmodule

`default_nettype wire

/* src/read_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module read_arbiter (
  input  logic                  clock,
  input  logic                  rst,

  // fetch port, reads only
  input  logic                  fetch_arvalid,
  output logic                  fetch_arready,
  input  core_bus_pkg::ar_req_t fetch_ar,
  output logic                  fetch_rvalid,
  input  logic                  fetch_rready,
  output core_bus_pkg::r_beat_t fetch_r,

  // load/store port, read side
  input  logic                  ls_arvalid,
  output logic                  ls_arready,
  input  core_bus_pkg::ar_req_t ls_ar,
  output logic                  ls_rvalid,
  input  logic                  ls_rready,
  output core_bus_pkg::r_beat_t ls_r,

  // shared read channel toward the router
  output logic                  bus_arvalid,
  input  logic                  bus_arready,
  output core_bus_pkg::ar_req_t bus_ar,
  input  logic                  bus_rvalid,
  output logic                  bus_rready,
  input  core_bus_pkg::r_beat_t bus_r
);

  logic busy;       // a burst is outstanding
  logic owner_ls;   // owner of the outstanding burst
  logic ls_grant;
  logic fetch_grant;
  logic ar_fire;
  logic r_done;

  // load/store wins when both ask in the same cycle
  always_comb begin
    if (busy) begin
      ls_grant    = owner_ls;
      fetch_grant = !owner_ls;
    end else begin
      ls_grant    = ls_arvalid;
      fetch_grant = fetch_arvalid && !ls_arvalid;
    end
  end

  // request side, only while idle
  assign bus_arvalid   = !busy && (ls_arvalid || fetch_arvalid);
  assign bus_ar        = ls_grant ? ls_ar : fetch_ar;
  assign ls_arready    = !busy && ls_grant && bus_arready;
  assign fetch_arready = !busy && fetch_grant && bus_arready;

  assign ar_fire = bus_arvalid && bus_arready;
  assign r_done  = bus_rvalid && bus_rready && bus_r.last;

  always_ff @(posedge clock) begin
    if (rst) begin
      busy     <= 1'b0;
      owner_ls <= 1'b0;
    end else if (ar_fire) begin
      busy     <= 1'b1;
      owner_ls <= ls_grant;
    end else if (r_done) begin
      busy     <= 1'b0;
    end
  end

  // responses go to the owner only
  assign ls_rvalid    = busy && owner_ls && bus_rvalid;
  assign fetch_rvalid = busy && !owner_ls && bus_rvalid;
  assign ls_r         = bus_r;
  assign fetch_r      = bus_r;
  assign bus_rready   = busy && (owner_ls ? ls_rready : fetch_rready);

  // a response only ever arrives for the granted burst
  a_r_granted: assert property (
    @(posedge clock) disable iff (rst) bus_rvalid |-> busy
  ) else $error("read_arbiter: read response with no granted burst");

endmodule

`default_nettype wire

/* src/read_router.sv */
`timescale 1ns/100ps
`default_nettype none

module read_router #(
  parameter logic [core_bus_pkg::addr_w-1:0] clint_base = core_bus_pkg::clint_base_default,
  parameter logic [core_bus_pkg::addr_w-1:0] clint_size = core_bus_pkg::clint_size_default
) (
  input  logic                  clock,
  input  logic                  rst,

  // granted read from the arbiter
  input  logic                  bus_arvalid,
  output logic                  bus_arready,
  input  core_bus_pkg::ar_req_t bus_ar,
  output logic                  bus_rvalid,
  input  logic                  bus_rready,
  output core_bus_pkg::r_beat_t bus_r,

  // external bus
  output logic                  ext_arvalid,
  input  logic                  ext_arready,
  output core_bus_pkg::ar_req_t ext_ar,
  input  logic                  ext_rvalid,
  output logic                  ext_rready,
  input  core_bus_pkg::r_beat_t ext_r,

  // timer
  output logic                  clint_arvalid,
  input  logic                  clint_arready,
  output core_bus_pkg::ar_req_t clint_ar,
  input  logic                  clint_rvalid,
  output logic                  clint_rready,
  input  core_bus_pkg::r_beat_t clint_r
);

  logic [core_bus_pkg::addr_w-1:0] win_offset;
  logic hit;          // current request falls in the timer window
  logic busy;
  logic tgt_clint;    // target latched at the ar transfer
  logic ar_fire;
  logic r_done;

  assign win_offset = bus_ar.addr - clint_base;
  assign hit        = (bus_ar.addr >= clint_base) && (win_offset < clint_size);

  // forward to one target, nothing new while a burst is open
  assign ext_arvalid   = !busy && bus_arvalid && !hit;
  assign clint_arvalid = !busy && bus_arvalid && hit;
  assign ext_ar        = bus_ar;
  assign clint_ar      = bus_ar;
  assign bus_arready   = !busy && (hit ? clint_arready : ext_arready);

  assign ar_fire = bus_arvalid && bus_arready;
  assign r_done  = bus_rvalid && bus_rready && bus_r.last;

  always_ff @(posedge clock) begin
    if (rst) begin
      busy      <= 1'b0;
      tgt_clint <= 1'b0;
    end else if (ar_fire) begin
      busy      <= 1'b1;
      tgt_clint <= hit;
    end else if (r_done) begin
      busy      <= 1'b0;
    end
  end

  // response path follows the latched target, not the live address
  assign bus_rvalid   = busy && (tgt_clint ? clint_rvalid : ext_rvalid);
  assign bus_r        = tgt_clint ? clint_r : ext_r;
  assign ext_rready   = busy && !tgt_clint && bus_rready;
  assign clint_rready = busy && tgt_clint && bus_rready;

  // a target only answers the burst that was sent to it
  a_ext_r_owner: assert property (
    @(posedge clock) disable iff (rst) ext_rvalid |-> busy && !tgt_clint
  ) else $error("read_router: external response with no external burst open");

  a_clint_r_owner: assert property (
    @(posedge clock) disable iff (rst) clint_rvalid |-> busy && tgt_clint
  ) else $error("read_router: timer response with no timer burst open");

endmodule

`default_nettype wire

/* verification/core_bus_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_bus_tb;

  localparam logic [31:0] clint_base = 32'h0200_0000;  // off the package default
  localparam logic [31:0] clint_size = 32'h0001_0000;
  localparam int timeout_cycles = 400;

  localparam logic [1:0] p_fetch = 2'd0;
  localparam logic [1:0] p_ls    = 2'd1;
  localparam logic [1:0] p_both  = 2'd2;  // fetch reads addr + 100 hex
  localparam logic       op_rd   = 1'b0;
  localparam logic       op_wr   = 1'b1;
  localparam logic [1:0] e_mem   = 2'd0;  // fill rule or written data
  localparam logic [1:0] e_okay  = 2'd1;
  localparam logic [1:0] e_tlo   = 2'd2;
  localparam logic [1:0] e_thi   = 2'd3;

  typedef struct packed {
    logic [1:0]  port;
    logic        op;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [1:0]  want;
  } row_t;

  localparam int num_rows = 10;
  localparam row_t rows [num_rows] = '{
    '{p_fetch, op_rd, 32'h0000_1000, 8'd3, 32'h0, 4'h0, e_mem},
    '{p_ls,    op_wr, 32'h0000_2004, 8'd0, 32'hdead_beef, 4'b0101, e_okay},
    '{p_ls,    op_rd, 32'h0000_2000, 8'd2, 32'h0, 4'h0, e_mem},
    '{p_ls,    op_rd, clint_base + core_bus_pkg::mtime_hi_offset, 8'd0, 32'h0, 4'h0, e_thi},
    '{p_ls,    op_rd, clint_base + core_bus_pkg::mtime_lo_offset, 8'd0, 32'h0, 4'h0, e_tlo},
    '{p_fetch, op_rd, 32'h0000_0300, 8'd1, 32'h0, 4'h0, e_mem},
    '{p_ls,    op_rd, clint_base + core_bus_pkg::mtime_lo_offset, 8'd0, 32'h0, 4'h0, e_tlo},
    '{p_both,  op_rd, 32'h0000_5000, 8'd1, 32'h0, 4'h0, e_mem},
    '{p_ls,    op_wr, 32'h0000_5104, 8'd0, 32'h1234_5678, 4'b1111, e_okay},
    '{p_both,  op_rd, 32'h0000_5004, 8'd1, 32'h0, 4'h0, e_mem}
  };

  logic clock = 1'b0;
  logic rst;
  logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
  logic ls_arvalid, ls_arready, ls_rvalid, ls_rready;
  logic ls_awvalid, ls_awready, ls_wvalid, ls_wready, ls_bvalid, ls_bready;
  logic ext_arvalid, ext_arready, ext_rvalid, ext_rready;
  logic ext_awvalid, ext_awready, ext_wvalid, ext_wready, ext_bvalid, ext_bready;
  core_bus_pkg::ar_req_t fetch_ar, ls_ar, ext_ar;
  core_bus_pkg::r_beat_t fetch_r, ls_r, ext_r;
  core_bus_pkg::aw_req_t ls_aw, ext_aw;
  core_bus_pkg::w_beat_t ls_w, ext_w;
  core_bus_pkg::b_resp_t ls_b, ext_b;
  logic        mem_stall;
  logic [15:0] ext_ar_count;

  logic [15:0] lfsr = 16'd87;
  int mismatches = 0;
  int failures = 0;
  int cycle = 0;
  core_bus_pkg::r_beat_t f_beats[$];
  core_bus_pkg::r_beat_t l_beats[$];
  int l_ar_cycle;
  int first_done;                       // 0 fetch, 1 ls, -1 none yet
  logic [31:0] shadow [logic [31:0]];   // words written so far

  core_bus_top #(
    .clint_base (clint_base),
    .clint_size (clint_size)
  ) dut (.*);

  ext_mem_model u_mem (
    .clock    (clock),
    .rst      (rst),
    .stall    (mem_stall),
    .ar_valid (ext_arvalid),
    .ar_ready (ext_arready),
    .ar       (ext_ar),
    .r_valid  (ext_rvalid),
    .r_ready  (ext_rready),
    .r        (ext_r),
    .aw_valid (ext_awvalid),
    .aw_ready (ext_awready),
    .aw       (ext_aw),
    .w_valid  (ext_wvalid),
    .w_ready  (ext_wready),
    .w        (ext_w),
    .b_valid  (ext_bvalid),
    .b_ready  (ext_bready),
    .b        (ext_b),
    .ar_count (ext_ar_count)
  );

  always #20 clock = !clock;
  always @(posedge clock) cycle <= cycle + 1;

  // galois lfsr, one step per bit
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hb400;
    return b;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return a ^ 32'h5a5a_5a5a;
  endfunction

  function automatic core_bus_pkg::ar_req_t make_ar(input logic [31:0] a, input logic [7:0] len,
                                                    input logic [3:0] id);
    return '{addr: a, id: id, len: len, size: 3'd2, burst: 2'b01};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic drive_random();
    fetch_rready = next_bit();
    ls_rready    = next_bit();
    mem_stall    = next_bit() & next_bit();  // stall about a quarter of the cycles
  endtask

  task automatic run_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [3:0] id);
    logic aw_done;
    logic w_done;
    logic b_done;
    int n;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_done  = 1'b0;
    n = 0;
    while (!b_done && n < timeout_cycles) begin
      @(negedge clock);
      ls_awvalid = !aw_done;
      ls_aw      = '{addr: addr, id: id, len: 8'd0, size: 3'd2, burst: 2'b01};
      ls_wvalid  = !w_done;
      ls_w       = '{data: data, strb: strb, last: 1'b1};
      ls_bready  = next_bit();
      drive_random();
      #10;  // mid low phase, everything settled
      if (ls_awvalid && ls_awready) aw_done = 1'b1;
      if (ls_wvalid && ls_wready) w_done = 1'b1;
      if (ls_bvalid && ls_bready) begin
        b_done = 1'b1;
        check_value("ls_b.resp", 64'(ls_b.resp), 64'(core_bus_pkg::resp_okay));
        check_value("ls_b.id", 64'(ls_b.id), 64'(id));
      end
      n++;
    end
    if (!b_done) begin
      $display("timeout: write to %h got no write response", addr);
      failures++;
    end
    @(negedge clock);
    ls_awvalid = 1'b0;
    ls_wvalid  = 1'b0;
    ls_bready  = 1'b0;
  endtask

  // both ports in one loop so same-cycle requests are possible
  task automatic run_reads(input logic do_f, input core_bus_pkg::ar_req_t f_req,
                           input logic do_l, input core_bus_pkg::ar_req_t l_req,
                           input int l_delay);
    logic f_sent;
    logic l_sent;
    logic f_done;
    logic l_done;
    logic f_hold;
    logic l_hold;
    core_bus_pkg::r_beat_t f_prev;
    core_bus_pkg::r_beat_t l_prev;
    int n;
    f_sent = !do_f;
    l_sent = !do_l;
    f_done = !do_f;
    l_done = !do_l;
    f_hold = 1'b0;
    l_hold = 1'b0;
    n = 0;
    first_done = -1;
    f_beats.delete();
    l_beats.delete();
    while (!(f_done && l_done) && n < timeout_cycles) begin
      @(negedge clock);
      fetch_arvalid = !f_sent;
      fetch_ar      = f_req;
      ls_arvalid    = !l_sent && n >= l_delay;
      ls_ar         = l_req;
      drive_random();
      #10;
      if (f_hold) begin  // stalled beat must still be there
        check_value("fetch_rvalid", 64'(fetch_rvalid), 64'd1);
        check_value("fetch_r", 64'(fetch_r), 64'(f_prev));
      end
      if (l_hold) begin
        check_value("ls_rvalid", 64'(ls_rvalid), 64'd1);
        check_value("ls_r", 64'(ls_r), 64'(l_prev));
      end
      if (fetch_rvalid && !(f_sent && !f_done)) begin
        $display("fetch port shows a read beat while no fetch read is open");
        failures++;
      end
      if (ls_rvalid && !(l_sent && !l_done)) begin
        $display("ls port shows a read beat while no ls read is open");
        failures++;
      end
      if (fetch_arvalid && fetch_arready) f_sent = 1'b1;
      if (ls_arvalid && ls_arready) begin
        l_sent = 1'b1;
        l_ar_cycle = cycle;
      end
      if (fetch_rvalid && fetch_rready) begin
        f_beats.push_back(fetch_r);
        if (fetch_r.last) begin
          f_done = 1'b1;
          if (first_done < 0) first_done = 0;
        end
      end
      if (ls_rvalid && ls_rready) begin
        l_beats.push_back(ls_r);
        if (ls_r.last) begin
          l_done = 1'b1;
          if (first_done < 0) first_done = 1;
        end
      end
      f_hold = fetch_rvalid && !fetch_rready;
      l_hold = ls_rvalid && !ls_rready;
      f_prev = fetch_r;
      l_prev = ls_r;
      n++;
    end
    if (!(f_done && l_done)) begin
      $display("timeout: read burst did not finish within %0d cycles", timeout_cycles);
      failures++;
    end
    @(negedge clock);
    fetch_arvalid = 1'b0;
    ls_arvalid    = 1'b0;
  endtask

  task automatic check_burst(input string name, input logic is_ls,
                             input core_bus_pkg::ar_req_t req, input logic [1:0] want);
    core_bus_pkg::r_beat_t b;
    int count;
    count = is_ls ? l_beats.size() : f_beats.size();
    check_value({name, " beat count"}, 64'(count), 64'(req.len) + 64'd1);
    for (int k = 0; k < count; k++) begin
      b = is_ls ? l_beats[k] : f_beats[k];
      check_value({name, "_r.resp"}, 64'(b.resp), 64'(core_bus_pkg::resp_okay));
      check_value({name, "_r.last"}, 64'(b.last), 64'(k == int'(req.len)));
      check_value({name, "_r.id"}, 64'(b.id), 64'(req.id));
      if (want == e_mem) begin
        check_value({name, "_r.data"}, 64'(b.data), 64'(expected_word(req.addr + 32'(4 * k))));
      end else if (want == e_thi) begin
        check_value({name, "_r.data"}, 64'(b.data), 64'd0);  // high word still zero
      end
    end
  endtask

  initial begin
    row_t row;
    core_bus_pkg::ar_req_t f_req;
    core_bus_pkg::ar_req_t l_req;
    logic do_f;
    logic do_l;
    int l_delay;
    int exp_ext;
    logic [31:0] wd;
    logic tlo_seen;
    logic [31:0] tlo_prev;
    int tlo_prev_cycle;
    rst           = 1'b1;
    fetch_arvalid = 1'b0;
    fetch_ar      = '0;
    fetch_rready  = 1'b0;
    ls_arvalid    = 1'b0;
    ls_ar         = '0;
    ls_rready     = 1'b0;
    ls_awvalid    = 1'b0;
    ls_aw         = '0;
    ls_wvalid     = 1'b0;
    ls_w          = '0;
    ls_bready     = 1'b0;
    mem_stall     = 1'b0;
    exp_ext       = 0;
    tlo_seen      = 1'b0;
    tlo_prev      = '0;
    tlo_prev_cycle = 0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;

    for (int i = 0; i < num_rows; i++) begin
      row = rows[i];
      if (row.op == op_wr) begin
        run_write(row.addr, row.wdata, row.strb, 4'(i));
        wd = expected_word(row.addr);
        for (int k = 0; k < 4; k++) begin
          if (row.strb[k]) wd[8*k +: 8] = row.wdata[8*k +: 8];
        end
        shadow[row.addr] = wd;
      end else begin
        do_f    = row.port != p_ls;
        do_l    = row.port != p_fetch;
        f_req   = make_ar(row.port == p_both ? row.addr + 32'h100 : row.addr, row.len, ~4'(i));
        l_req   = make_ar(row.addr, row.len, 4'(i));
        l_delay = (row.port == p_both && next_bit()) ? 1 : 0;
        // only memory rows may reach the external port
        if (row.want == e_mem && do_f) exp_ext++;
        if (row.want == e_mem && do_l) exp_ext++;
        run_reads(do_f, f_req, do_l, l_req, l_delay);
        if (do_f) check_burst("fetch", 1'b0, f_req, row.want);
        if (do_l) check_burst("ls", 1'b1, l_req, row.want);
        if (row.port == p_both && l_delay == 0 && first_done != 1) begin
          $display("same-cycle requests: the ls read did not finish before the fetch read");
          failures++;
        end
        if (row.want == e_tlo && l_beats.size() == 1) begin
          // mtime advances once per cycle between the two ar transfers
          if (tlo_seen) begin
            check_value("mtime delta", 64'(l_beats[0].data - tlo_prev),
                        64'(l_ar_cycle - tlo_prev_cycle));
          end
          tlo_seen       = 1'b1;
          tlo_prev       = l_beats[0].data;
          tlo_prev_cycle = l_ar_cycle;
        end
      end
    end

    check_value("ext_ar transfers", 64'(ext_ar_count), 64'(exp_ext));
    $display("errors: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/ext_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_mem_model (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  stall,      // random hold-off, driven by the testbench
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  core_bus_pkg::ar_req_t ar,
  output logic                  r_valid,
  input  logic                  r_ready,
  output core_bus_pkg::r_beat_t r,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  core_bus_pkg::aw_req_t aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  core_bus_pkg::w_beat_t w,
  output logic                  b_valid,
  input  logic                  b_ready,
  output core_bus_pkg::b_resp_t b,
  output logic [15:0]           ar_count    // read bursts accepted
);

  logic [31:0] mem [logic [31:0]];  // sparse, unwritten words follow the fill rule
  logic        rd_busy;
  logic [31:0] rd_addr;
  logic [7:0]  rd_left;
  logic [3:0]  rd_id;
  logic        wr_busy;
  logic [31:0] wr_addr;

  function automatic logic [31:0] word_at(input logic [31:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input core_bus_pkg::w_beat_t beat);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (beat.strb[i]) res[8*i +: 8] = beat.data[8*i +: 8];
    end
    return res;
  endfunction

  assign ar_ready = !rd_busy && !stall;
  assign aw_ready = !wr_busy && !stall;
  assign w_ready  = wr_busy && !b_valid && !stall;

  // one burst at a time, a gap cycle after every beat
  always @(posedge clock) begin
    if (rst) begin
      rd_busy  <= 1'b0;
      r_valid  <= 1'b0;
      ar_count <= '0;
    end else if (ar_valid && ar_ready) begin
      rd_busy  <= 1'b1;
      rd_addr  <= ar.addr;
      rd_left  <= ar.len;
      rd_id    <= ar.id;
      ar_count <= ar_count + 16'd1;
    end else if (r_valid && r_ready) begin
      r_valid <= 1'b0;
      rd_addr <= rd_addr + 32'd4;
      rd_left <= rd_left - 8'd1;
      rd_busy <= !r.last;
    end else if (rd_busy && !r_valid && !stall) begin
      r_valid <= 1'b1;
      r.data  <= word_at(rd_addr);
      r.resp  <= core_bus_pkg::resp_okay;
      r.last  <= rd_left == 8'd0;
      r.id    <= rd_id;
    end
  end

  always @(posedge clock) begin
    if (rst) begin
      wr_busy <= 1'b0;
      b_valid <= 1'b0;
    end else if (aw_valid && aw_ready) begin
      wr_busy <= 1'b1;
      wr_addr <= aw.addr;
      b.id    <= aw.id;
      b.resp  <= core_bus_pkg::resp_okay;
    end else if (w_valid && w_ready) begin
      mem[wr_addr] = merge(word_at(wr_addr), w);  // strobed bytes only
      wr_addr <= wr_addr + 32'd4;
      b_valid <= w.last;
    end else if (b_valid && b_ready) begin
      b_valid <= 1'b0;
      wr_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire
